// File: exp_sequencer.sv
// ==================================================================
// left-to-right binary exponent scan; schedules each Montgomery
// product on the engine and holds m_bar and c_bar between products
// ==================================================================
`default_nettype none

module exp_sequencer #(
    parameter int NUM_WORDS = mont_pkg::DEFAULT_NUM_WORDS
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    start_compute,
    input  logic                                    operands_loaded,
    input  logic [NUM_WORDS*mont_pkg::WORD_WIDTH-1:0] m_vec,
    input  logic [NUM_WORDS*mont_pkg::WORD_WIDTH-1:0] e_vec,
    input  logic [NUM_WORDS*mont_pkg::WORD_WIDTH-1:0] r_vec,
    input  logic [NUM_WORDS*mont_pkg::WORD_WIDTH-1:0] t_vec,
    input  logic                                    mp_done,
    input  logic [NUM_WORDS*mont_pkg::WORD_WIDTH-1:0] mp_result,
    input  logic                                    unload_done,
    output logic                                    mp_start,
    output logic [NUM_WORDS*mont_pkg::WORD_WIDTH-1:0] mp_a,
    output logic [NUM_WORDS*mont_pkg::WORD_WIDTH-1:0] mp_b,
    output logic [NUM_WORDS*mont_pkg::WORD_WIDTH-1:0] result_vec,
    output logic                                    result_ready
);
    import mont_pkg::*;

    localparam int BITS = NUM_WORDS * WORD_WIDTH;
    localparam int PW   = $clog2(BITS);
    localparam logic [PW-1:0]   PTR_TOP = PW'(BITS - 1);
    localparam logic [BITS-1:0] ONE_VEC = BITS'(1);

    exp_state_t      state;
    logic [PW-1:0]   bit_ptr;  // current exponent bit
    logic [BITS-1:0] m_bar;
    logic [BITS-1:0] c_bar;
    logic            accept;

    assign accept       = (state == EX_IDLE) && start_compute && operands_loaded;
    assign result_ready = (state == EX_DONE);
    assign result_vec   = c_bar;

    // operands stay put for the whole product since state only moves on mp_done
    always_comb begin
        case (state)
            EX_TO_MONT: begin
                mp_a = m_vec;
                mp_b = t_vec;
            end
            EX_MULTIPLY: begin
                mp_a = c_bar;
                mp_b = m_bar;
            end
            EX_FROM_MONT: begin
                mp_a = c_bar;
                mp_b = ONE_VEC;
            end
            default: begin
                mp_a = c_bar;
                mp_b = c_bar;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= EX_IDLE;
            bit_ptr  <= '0;
            mp_start <= 1'b0;
        end else begin
            mp_start <= 1'b0;
            case (state)
                EX_IDLE: begin
                    if (accept) begin
                        state    <= EX_TO_MONT;
                        mp_start <= 1'b1;
                    end
                end
                EX_TO_MONT: begin
                    if (mp_done) begin
                        state   <= EX_FIND_TOP;
                        bit_ptr <= PTR_TOP;
                    end
                end
                EX_FIND_TOP: begin
                    if (e_vec[bit_ptr]) begin
                        state    <= EX_SQUARE;
                        mp_start <= 1'b1;
                    end else begin
                        bit_ptr <= bit_ptr - 1'b1;
                    end
                end
                EX_SQUARE: begin
                    if (mp_done) begin
                        mp_start <= 1'b1;
                        if (e_vec[bit_ptr]) begin
                            state <= EX_MULTIPLY;
                        end else if (bit_ptr == '0) begin
                            state <= EX_FROM_MONT;
                        end else begin
                            bit_ptr <= bit_ptr - 1'b1;  // square again
                        end
                    end
                end
                EX_MULTIPLY: begin
                    if (mp_done) begin
                        mp_start <= 1'b1;
                        if (bit_ptr == '0) begin
                            state <= EX_FROM_MONT;
                        end else begin
                            bit_ptr <= bit_ptr - 1'b1;
                            state   <= EX_SQUARE;
                        end
                    end
                end
                EX_FROM_MONT: begin
                    if (mp_done) begin
                        state <= EX_DONE;
                    end
                end
                EX_DONE: begin
                    if (unload_done) begin
                        state <= EX_IDLE;
                    end
                end
                default: state <= EX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            c_bar <= r_vec;  // R mod n, Montgomery form of 1
        end
        if (mp_done) begin
            if (state == EX_TO_MONT) begin
                m_bar <= mp_result;
            end else begin
                c_bar <= mp_result;
            end
        end
    end

    a_exponent_nonzero: assert property (
        @(posedge clk) disable iff (reset) accept |-> (|e_vec)
    );

    // operands must not be reloaded under a running exponentiation
    a_operands_held: assert property (
        @(posedge clk) disable iff (reset) (state != EX_IDLE) |-> operands_loaded
    );

endmodule

`default_nettype wire

// File: list.f
mont_pkg.sv
operand_loader.sv
monpro_engine.sv
exp_sequencer.sv
result_unloader.sv
mod_exp_top.sv
tb_mod_exp.sv

// File: mod_exp_testdata.txt
# per test: name m e / n r t nprime0 / expected m^e mod n, all values in hex
# r = 2^128 mod n, t = 2^256 mod n, nprime0 = -n^-1 mod 2^32 in its low word
e_one 123456789ABCDEFFEDCBA98 1
1000000000000000000000001 FFFFFFFFFFFFFFFF00000001 10000000000000000 FFFFFFFF
123456789ABCDEFFEDCBA98
square 100000000000000000003 2
1000000000000000000000001 FFFFFFFFFFFFFFFF00000001 10000000000000000 FFFFFFFF
5FFFF0000000000000009
pow_mid 20 1234
1000000000000000000000001 FFFFFFFFFFFFFFFF00000001 10000000000000000 FFFFFFFF
100000000000000000
neg_base FFFFFFFFFFFFFFFFFFFFFC01 1B
1000000000000000000000001 FFFFFFFFFFFFFFFF00000001 10000000000000000 FFFFFFFF
FFFFC0000000000000000001
top_bit 80 80000000000000000000000000000001
1000000000000000000000001 FFFFFFFFFFFFFFFF00000001 10000000000000000 FFFFFFFF
FFFFFFFFFFFFFF8000000001
wide_n 8 ABCDEF
20000000000000000000000000000001 1FFFFFFFFFFFFFFFFFFFFFFFFFFFFFF9 40 FFFFFFFF
20000000000000000000000000000000
wide_top 10000000000000000000000000 80000000000000000000000000000001
20000000000000000000000000000001 1FFFFFFFFFFFFFFFFFFFFFFFFFFFFFF9 40 FFFFFFFF
1FFFFFFFFFFFFFFFFFFFFFFFFE000001

// File: mod_exp_top.sv
// ==================================================================
// modular exponentiator m^e mod n; load operands, start_compute,
// then get_result once result_ready is high
// ==================================================================
`default_nettype none

module mod_exp_top #(
    parameter int NUM_WORDS = mont_pkg::DEFAULT_NUM_WORDS
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            start_input,
    input  logic            start_compute,
    input  logic            get_result,
    input  mont_pkg::word_t m_word,
    input  mont_pkg::word_t e_word,
    input  mont_pkg::word_t n_word,
    input  mont_pkg::word_t r_word,
    input  mont_pkg::word_t t_word,
    input  mont_pkg::word_t nprime0,
    output mont_pkg::word_t res_out,
    output logic            res_valid,
    output logic            result_ready
);
    import mont_pkg::*;

    logic [NUM_WORDS*WORD_WIDTH-1:0] m_vec;
    logic [NUM_WORDS*WORD_WIDTH-1:0] e_vec;
    logic [NUM_WORDS*WORD_WIDTH-1:0] n_vec;
    logic [NUM_WORDS*WORD_WIDTH-1:0] r_vec;
    logic [NUM_WORDS*WORD_WIDTH-1:0] t_vec;
    logic [NUM_WORDS*WORD_WIDTH-1:0] mp_a;
    logic [NUM_WORDS*WORD_WIDTH-1:0] mp_b;
    logic [NUM_WORDS*WORD_WIDTH-1:0] mp_result;
    logic [NUM_WORDS*WORD_WIDTH-1:0] result_vec;
    word_t n_prime;
    logic  operands_loaded;
    logic  mp_start;
    logic  mp_done;
    logic  unload_done;

    operand_loader #(.NUM_WORDS(NUM_WORDS)) operand_loader_i (
        .clk(clk), .reset(reset), .start_input(start_input),
        .m_word(m_word), .e_word(e_word), .n_word(n_word),
        .r_word(r_word), .t_word(t_word), .nprime0(nprime0),
        .m_vec(m_vec), .e_vec(e_vec), .n_vec(n_vec), .r_vec(r_vec), .t_vec(t_vec),
        .n_prime(n_prime), .operands_loaded(operands_loaded)
    );

    exp_sequencer #(.NUM_WORDS(NUM_WORDS)) exp_sequencer_i (
        .clk(clk), .reset(reset), .start_compute(start_compute),
        .operands_loaded(operands_loaded),
        .m_vec(m_vec), .e_vec(e_vec), .r_vec(r_vec), .t_vec(t_vec),
        .mp_done(mp_done), .mp_result(mp_result), .unload_done(unload_done),
        .mp_start(mp_start), .mp_a(mp_a), .mp_b(mp_b),
        .result_vec(result_vec), .result_ready(result_ready)
    );

    monpro_engine #(.NUM_WORDS(NUM_WORDS)) monpro_engine_i (
        .clk(clk), .reset(reset), .mp_start(mp_start),
        .mp_a(mp_a), .mp_b(mp_b), .n_vec(n_vec), .n_prime(n_prime),
        .mp_done(mp_done), .mp_result(mp_result)
    );

    result_unloader #(.NUM_WORDS(NUM_WORDS)) result_unloader_i (
        .clk(clk), .reset(reset), .get_result(get_result),
        .result_ready(result_ready), .result_vec(result_vec),
        .res_out(res_out), .res_valid(res_valid), .unload_done(unload_done)
    );

endmodule

`default_nettype wire

// File: monpro_engine.sv
// ==================================================================
// word-serial CIOS Montgomery product, a * b * R^-1 mod n, through
// one registered multiply-accumulate; fixed latency per product
// ==================================================================
`default_nettype none

module monpro_engine #(
    parameter int NUM_WORDS = mont_pkg::DEFAULT_NUM_WORDS
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    mp_start,
    input  logic [NUM_WORDS*mont_pkg::WORD_WIDTH-1:0] mp_a,
    input  logic [NUM_WORDS*mont_pkg::WORD_WIDTH-1:0] mp_b,
    input  logic [NUM_WORDS*mont_pkg::WORD_WIDTH-1:0] n_vec,
    input  mont_pkg::word_t                         n_prime,
    output logic                                    mp_done,
    output logic [NUM_WORDS*mont_pkg::WORD_WIDTH-1:0] mp_result
);
    import mont_pkg::*;

    localparam int IW = (NUM_WORDS > 1) ? $clog2(NUM_WORDS) : 1;
    localparam logic [IW-1:0] LAST_IDX = IW'(NUM_WORDS - 1);

    monpro_phase_t phase;
    logic [IW-1:0] i_idx;    // word of mp_a
    logic [IW-1:0] j_idx;    // word of mp_b / n_vec
    logic          capture;  // second half of a MAC step

    word_t acc [NUM_WORDS+2];  // running product plus two guard words
    word_t carry;
    word_t q;
    wide_t mac_q;
    word_t mac_x;
    word_t mac_y;
    word_t mac_z;
    word_t mac_c;
    word_t mac_lo;
    word_t mac_hi;

    assign mac_lo  = mac_q[WORD_WIDTH-1:0];
    assign mac_hi  = mac_q[2*WORD_WIDTH-1:WORD_WIDTH];
    assign mp_done = (phase == MP_FINISH);

    always_comb begin
        for (int k = 0; k < NUM_WORDS; k++) begin
            mp_result[k*WORD_WIDTH +: WORD_WIDTH] = acc[k];
        end
    end

    // operand select for the issue half
    always_comb begin
        mac_x = '0;
        mac_y = '0;
        mac_z = '0;
        mac_c = carry;
        case (phase)
            MP_MUL_PASS: begin
                mac_x = mp_a[i_idx*WORD_WIDTH +: WORD_WIDTH];
                mac_y = mp_b[j_idx*WORD_WIDTH +: WORD_WIDTH];
                mac_z = acc[j_idx];
                if (j_idx == '0) begin
                    mac_c = '0;
                end
            end
            MP_CARRY_FOLD, MP_SHIFT_TOP: mac_z = acc[NUM_WORDS];
            MP_QUOTIENT: begin
                mac_x = acc[0];
                mac_y = n_prime;
                mac_c = '0;
            end
            MP_REDUCE_PASS: begin
                mac_x = q;
                mac_y = n_vec[j_idx*WORD_WIDTH +: WORD_WIDTH];
                mac_z = acc[j_idx];
                if (j_idx == '0) begin
                    mac_c = '0;
                end
            end
            MP_SHIFT_CARRY: mac_z = acc[NUM_WORDS+1];
            default: mac_c = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase   <= MP_IDLE;
            i_idx   <= '0;
            j_idx   <= '0;
            capture <= 1'b0;
        end else if (phase == MP_IDLE) begin
            if (mp_start) begin
                phase   <= MP_MUL_PASS;
                i_idx   <= '0;
                j_idx   <= '0;
                capture <= 1'b0;
            end
        end else if (phase == MP_FINISH) begin
            phase <= MP_IDLE;  // mp_done lasts one cycle
        end else if (!capture) begin
            capture <= 1'b1;
        end else begin
            capture <= 1'b0;
            case (phase)
                MP_MUL_PASS, MP_REDUCE_PASS: begin
                    if (j_idx == LAST_IDX) begin
                        j_idx <= '0;
                        phase <= (phase == MP_MUL_PASS) ? MP_CARRY_FOLD : MP_SHIFT_TOP;
                    end else begin
                        j_idx <= j_idx + 1'b1;
                    end
                end
                MP_CARRY_FOLD: phase <= MP_QUOTIENT;
                MP_QUOTIENT:   phase <= MP_REDUCE_PASS;
                MP_SHIFT_TOP:  phase <= MP_SHIFT_CARRY;
                MP_SHIFT_CARRY: begin
                    if (i_idx == LAST_IDX) begin
                        phase <= MP_FINISH;
                    end else begin
                        i_idx <= i_idx + 1'b1;
                        phase <= MP_MUL_PASS;
                    end
                end
                default: phase <= MP_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (phase == MP_IDLE && mp_start) begin
            for (int k = 0; k < NUM_WORDS + 2; k++) begin
                acc[k] <= '0;
            end
        end else if (phase != MP_IDLE && phase != MP_FINISH) begin
            if (!capture) begin
                mac_q <= wide_t'(mac_x) * wide_t'(mac_y) + wide_t'(mac_z) + wide_t'(mac_c);
            end else begin
                case (phase)
                    MP_MUL_PASS: begin
                        acc[j_idx] <= mac_lo;
                        carry      <= mac_hi;
                    end
                    MP_CARRY_FOLD: begin
                        acc[NUM_WORDS]   <= mac_lo;
                        acc[NUM_WORDS+1] <= mac_hi;
                    end
                    MP_QUOTIENT: q <= mac_lo;  // low word only, mod 2^W
                    MP_REDUCE_PASS: begin
                        if (j_idx != '0) begin
                            acc[j_idx - 1'b1] <= mac_lo;  // shift down one word
                        end
                        carry <= mac_hi;
                    end
                    MP_SHIFT_TOP: begin
                        acc[NUM_WORDS-1] <= mac_lo;
                        carry            <= mac_hi;
                    end
                    MP_SHIFT_CARRY: acc[NUM_WORDS] <= mac_lo;
                    default: ;
                endcase
            end
        end
    end

    // the sequencer must wait for mp_done before the next product
    a_start_only_idle: assert property (
        @(posedge clk) disable iff (reset) mp_start |-> phase == MP_IDLE
    );

endmodule

`default_nettype wire

// File: mont_pkg.sv
// ==================================================================
// shared word types and FSM encodings for the modular exponentiator
// import into each module body that uses them
// ==================================================================
`default_nettype none

package mont_pkg;

    localparam int WORD_WIDTH        = 32;  // multiplier operand width
    localparam int DEFAULT_NUM_WORDS = 4;   // 128-bit operands

    typedef logic [WORD_WIDTH-1:0]   word_t;
    typedef logic [2*WORD_WIDTH-1:0] wide_t;  // {carry, sum} of one MAC

    typedef enum logic [2:0] {
        MP_IDLE,
        MP_MUL_PASS,     // acc += a[i] * b
        MP_CARRY_FOLD,   // fold carry into the top words
        MP_QUOTIENT,     // q = acc[0] * n' mod 2^W
        MP_REDUCE_PASS,  // acc = (acc + q * n) >> W
        MP_SHIFT_TOP,
        MP_SHIFT_CARRY,
        MP_FINISH
    } monpro_phase_t;

    typedef enum logic [2:0] {
        EX_IDLE,
        EX_TO_MONT,    // m_bar = MonPro(m, t)
        EX_FIND_TOP,   // seek the top set bit of e
        EX_SQUARE,
        EX_MULTIPLY,
        EX_FROM_MONT,  // c = MonPro(c_bar, 1)
        EX_DONE
    } exp_state_t;

endpackage

`default_nettype wire

// File: operand_loader.sv
// ==================================================================
// captures the operand word streams, least significant word first,
// during the NUM_WORDS cycles that follow a start_input strobe
// ==================================================================
`default_nettype none

module operand_loader #(
    parameter int NUM_WORDS = mont_pkg::DEFAULT_NUM_WORDS
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    start_input,
    input  mont_pkg::word_t                         m_word,
    input  mont_pkg::word_t                         e_word,
    input  mont_pkg::word_t                         n_word,
    input  mont_pkg::word_t                         r_word,
    input  mont_pkg::word_t                         t_word,
    input  mont_pkg::word_t                         nprime0,
    output logic [NUM_WORDS*mont_pkg::WORD_WIDTH-1:0] m_vec,
    output logic [NUM_WORDS*mont_pkg::WORD_WIDTH-1:0] e_vec,
    output logic [NUM_WORDS*mont_pkg::WORD_WIDTH-1:0] n_vec,
    output logic [NUM_WORDS*mont_pkg::WORD_WIDTH-1:0] r_vec,
    output logic [NUM_WORDS*mont_pkg::WORD_WIDTH-1:0] t_vec,
    output mont_pkg::word_t                         n_prime,
    output logic                                    operands_loaded
);
    import mont_pkg::*;

    localparam int IW = (NUM_WORDS > 1) ? $clog2(NUM_WORDS) : 1;
    localparam logic [IW-1:0] LAST_WORD = IW'(NUM_WORDS - 1);

    logic          loading;  // inside the load window
    logic [IW-1:0] word_cnt;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            loading         <= 1'b0;
            word_cnt        <= '0;
            operands_loaded <= 1'b0;
        end else if (start_input) begin
            loading         <= 1'b1;  // this edge captures nothing
            word_cnt        <= '0;
            operands_loaded <= 1'b0;
        end else if (loading) begin
            if (word_cnt == LAST_WORD) begin
                loading         <= 1'b0;
                operands_loaded <= 1'b1;
            end else begin
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (loading) begin
            m_vec[word_cnt*WORD_WIDTH +: WORD_WIDTH] <= m_word;
            e_vec[word_cnt*WORD_WIDTH +: WORD_WIDTH] <= e_word;
            n_vec[word_cnt*WORD_WIDTH +: WORD_WIDTH] <= n_word;
            r_vec[word_cnt*WORD_WIDTH +: WORD_WIDTH] <= r_word;
            t_vec[word_cnt*WORD_WIDTH +: WORD_WIDTH] <= t_word;
            if (word_cnt == '0) begin
                n_prime <= nprime0;  // sampled alongside word 0
            end
        end
    end

    // a restart inside the window would leave a mix of two operand sets
    a_no_restart_in_load: assert property (
        @(posedge clk) disable iff (reset) loading |-> !start_input
    );

endmodule

`default_nettype wire

// File: result_unloader.sv
// ==================================================================
// streams the finished result one word per cycle on get_result
// ==================================================================
`default_nettype none

module result_unloader #(
    parameter int NUM_WORDS = mont_pkg::DEFAULT_NUM_WORDS
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    get_result,
    input  logic                                    result_ready,
    input  logic [NUM_WORDS*mont_pkg::WORD_WIDTH-1:0] result_vec,
    output mont_pkg::word_t                         res_out,
    output logic                                    res_valid,
    output logic                                    unload_done
);
    import mont_pkg::*;

    localparam int IW = (NUM_WORDS > 1) ? $clog2(NUM_WORDS) : 1;
    localparam logic [IW-1:0] LAST_WORD = IW'(NUM_WORDS - 1);

    logic [IW-1:0] word_cnt;  // word now on res_out

    assign unload_done = res_valid && (word_cnt == LAST_WORD);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            res_valid <= 1'b0;
            res_out   <= '0;
            word_cnt  <= '0;
        end else if (res_valid) begin
            if (word_cnt == LAST_WORD) begin
                res_valid <= 1'b0;
                res_out   <= '0;  // bus idles at zero
            end else begin
                word_cnt <= word_cnt + 1'b1;
                res_out  <= result_vec[(word_cnt + 1'b1)*WORD_WIDTH +: WORD_WIDTH];
            end
        end else if (get_result && result_ready) begin
            res_valid <= 1'b1;
            word_cnt  <= '0;
            res_out   <= result_vec[WORD_WIDTH-1:0];  // lsw first
        end
    end

endmodule

`default_nettype wire

// File: tb_mod_exp.sv
// ==================================================================
// testbench for the modular exponentiator; runs load, compute and
// unload for every vector of the data file and checks each word
// ==================================================================
`default_nettype none

module tb_mod_exp;
    import mont_pkg::*;

    localparam int NUM_WORDS = 4;
    localparam int BITS      = NUM_WORDS * WORD_WIDTH;
    localparam int MAX_TESTS = 32;
    localparam int MP_CYCLES = NUM_WORDS * (4 * NUM_WORDS + 8) + 1;  // one MonPro

    logic  clk;
    logic  reset;
    logic  start_input;
    logic  start_compute;
    logic  get_result;
    word_t m_word;
    word_t e_word;
    word_t n_word;
    word_t r_word;
    word_t t_word;
    word_t nprime0;
    word_t res_out;
    logic  res_valid;
    logic  result_ready;

    logic [8*24-1:0] name_tab [MAX_TESTS];
    logic [BITS-1:0] m_tab    [MAX_TESTS];
    logic [BITS-1:0] e_tab    [MAX_TESTS];
    logic [BITS-1:0] n_tab    [MAX_TESTS];
    logic [BITS-1:0] r_tab    [MAX_TESTS];
    logic [BITS-1:0] t_tab    [MAX_TESTS];
    logic [BITS-1:0] np_tab   [MAX_TESTS];
    logic [BITS-1:0] exp_tab  [MAX_TESTS];

    int   num_tests;
    int   checks;
    int   errors;
    int   test_errors;
    int   timeout_cycles;
    logic watchdog_armed;

    mod_exp_top #(.NUM_WORDS(NUM_WORDS)) mod_exp_top_i (
        .clk(clk), .reset(reset), .start_input(start_input),
        .start_compute(start_compute), .get_result(get_result),
        .m_word(m_word), .e_word(e_word), .n_word(n_word),
        .r_word(r_word), .t_word(t_word), .nprime0(nprime0),
        .res_out(res_out), .res_valid(res_valid), .result_ready(result_ready)
    );

    always #4 clk = ~clk;

    task automatic check_value(input string what, input logic [BITS-1:0] expected,
                               input logic [BITS-1:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            test_errors++;
            $display("CHECK FAILED %0s: expected %h, actual %h", what, expected, actual);
        end
    endtask

    task automatic read_vectors();
        int              fd;
        int              got;
        logic            done;
        logic [8*24-1:0] tok;
        logic [8*256-1:0] rest;
        logic [BITS-1:0] f_m, f_e, f_n, f_r, f_t, f_np, f_exp;
        done = 1'b0;
        fd = $fopen("mod_exp_testdata.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open mod_exp_testdata.txt");
            errors++;
        end else begin
            while (!done && num_tests < MAX_TESTS) begin
                tok = '0;
                got = $fscanf(fd, "%s", tok);
                if (got != 1) begin
                    done = 1'b1;  // end of file
                end else if (tok == "#") begin
                    got = $fgets(rest, fd);  // rest of a comment line
                end else begin
                    got = $fscanf(fd, "%h %h %h %h %h %h %h",
                                  f_m, f_e, f_n, f_r, f_t, f_np, f_exp);
                    if (got == 7) begin
                        name_tab[num_tests] = tok;
                        m_tab[num_tests]    = f_m;
                        e_tab[num_tests]    = f_e;
                        n_tab[num_tests]    = f_n;
                        r_tab[num_tests]    = f_r;
                        t_tab[num_tests]    = f_t;
                        np_tab[num_tests]   = f_np;
                        exp_tab[num_tests]  = f_exp;
                        num_tests++;
                    end else begin
                        $display("error: vector %0s in the data file is incomplete", tok);
                        errors++;
                        done = 1'b1;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // start_input strobe, then one word per cycle, lsw first
    task automatic load_operands(input int idx);
        @(negedge clk);
        start_input = 1'b1;
        for (int k = 0; k < NUM_WORDS; k++) begin
            @(negedge clk);
            start_input = 1'b0;
            m_word  = m_tab[idx][k*WORD_WIDTH +: WORD_WIDTH];
            e_word  = e_tab[idx][k*WORD_WIDTH +: WORD_WIDTH];
            n_word  = n_tab[idx][k*WORD_WIDTH +: WORD_WIDTH];
            r_word  = r_tab[idx][k*WORD_WIDTH +: WORD_WIDTH];
            t_word  = t_tab[idx][k*WORD_WIDTH +: WORD_WIDTH];
            nprime0 = np_tab[idx][k*WORD_WIDTH +: WORD_WIDTH];
        end
        @(negedge clk);
        m_word  = '0;
        e_word  = '0;
        n_word  = '0;
        r_word  = '0;
        t_word  = '0;
        nprime0 = '0;
    endtask

    // a get_result during the computation must be ignored
    task automatic run_compute(input int idx);
        int early_valid;
        early_valid = 0;
        start_compute = 1'b1;
        @(negedge clk);
        start_compute = 1'b0;
        get_result    = 1'b1;  // too early
        @(negedge clk);
        get_result = 1'b0;
        while (!result_ready) begin
            if (res_valid) begin
                early_valid++;
            end
            @(negedge clk);
        end
        repeat (2) begin  // a held early request would start the frame here
            @(negedge clk);
            if (res_valid) begin
                early_valid++;
            end
        end
        check_value($sformatf("%0s early res_valid cycles", name_tab[idx]), 0, early_valid);
    endtask

    task automatic unload_and_check(input int idx);
        get_result = 1'b1;
        for (int k = 0; k < NUM_WORDS; k++) begin
            @(negedge clk);
            get_result = 1'b0;
            check_value($sformatf("%0s res_valid at word %0d", name_tab[idx], k), 1, res_valid);
            check_value($sformatf("%0s word %0d", name_tab[idx], k),
                        exp_tab[idx][k*WORD_WIDTH +: WORD_WIDTH], res_out);
        end
        @(negedge clk);
        check_value($sformatf("%0s res_valid after frame", name_tab[idx]), 0, res_valid);
        check_value($sformatf("%0s res_out after frame", name_tab[idx]), 0, res_out);
        check_value($sformatf("%0s result_ready after unload", name_tab[idx]), 0, result_ready);
    endtask

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        start_input    = 1'b0;
        start_compute  = 1'b0;
        get_result     = 1'b0;
        m_word         = '0;
        e_word         = '0;
        n_word         = '0;
        r_word         = '0;
        t_word         = '0;
        nprime0        = '0;
        num_tests      = 0;
        checks         = 0;
        errors         = 0;
        test_errors    = 0;
        watchdog_armed = 1'b0;
        read_vectors();
        // worst case e has all 128 bits set, plus load, scan and unload
        timeout_cycles = (num_tests + 1)
                       * ((2 * BITS + 2) * (MP_CYCLES + 2) + BITS + 16 * NUM_WORDS + 64);
        watchdog_armed = 1'b1;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_value("reset res_valid", 0, res_valid);
        check_value("reset result_ready", 0, result_ready);
        check_value("reset res_out", 0, res_out);
        for (int idx = 0; idx < num_tests; idx++) begin
            test_errors = 0;
            load_operands(idx);
            run_compute(idx);
            unload_and_check(idx);
            if (test_errors == 0) begin
                $display("test %0s: ok", name_tab[idx]);
            end else begin
                $display("test %0s: %0d mismatches", name_tab[idx], test_errors);
            end
        end
        if (num_tests == 0) begin
            $display("error: no test vectors were read");
            errors++;
        end
        $display("summary: %0d tests, %0d checks, %0d errors", num_tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        wait (watchdog_armed === 1'b1);
        repeat (timeout_cycles) @(posedge clk);
        $display("error: timeout, the run did not finish within %0d clock cycles",
                 timeout_cycles);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire
